// ==== common/csr_if.sv ====
`timescale 1ns/1ps

// CSR access port, combinational read, write at the clock edge
interface csr_if import riscv_pkg::*; ();

    csr_addr_t addr;   // CSR number from the instruction
    xlen_t     wdata;  // New value
    logic      we;     // Write at the next edge
    xlen_t     rdata;  // Current value, old one during a write

    modport req (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport rsp (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// ==== common/mem_bus_if.sv ====
`timescale 1ns/1ps

// Data bus, single-cycle strobes and no wait states
interface mem_bus_if import riscv_pkg::*; ();

    xlen_t address;       // Byte address of the access
    xlen_t write_data;
    logic  write_enable;  // One-cycle write strobe
    logic  read_enable;   // One-cycle read strobe
    xlen_t read_data;     // Sampled at the edge ending the read strobe

    // Trap controller side
    modport master (
        output address,
        output write_data,
        output write_enable,
        output read_enable,
        input  read_data
    );

    // Memory / top-level port side
    modport slave (
        input  address,
        input  write_data,
        input  write_enable,
        input  read_enable,
        output read_data
    );

endinterface

// ==== common/riscv_params.svh ====
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Memory map of the interrupt peripherals

// Key register, read when the key interrupt fires
`define KEY_BASE 64'h0000_0000_8000_0010

// Display register, receives a copy of the key value
`define ART_BASE 64'h0000_0000_8000_0000

// Fetch address after reset
`define RESET_PC 32'h0000_0000

// Value of interrupt_vector that selects the key source
`define KEY_IRQ_SRC 4'd1

`endif

// ==== common/riscv_pkg.sv ====
package riscv_pkg;

    typedef logic [63:0] xlen_t;      // One register word
    typedef logic [31:0] instr_t;     // One instruction word
    typedef logic [4:0]  reg_idx_t;   // x0..x31
    typedef logic [11:0] csr_addr_t;  // CSR space index

    // Major opcodes, bits 6:0 of the instruction
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // funct3 / funct7 fields of the supported forms
    localparam logic [2:0] F3_ADD   = 3'b000;  // Shared by ADDI and ADD
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [6:0] F7_ADD   = 7'b0000000;

    // Machine CSRs held by the trap controller
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    localparam int MSTATUS_MIE = 3;   // Global machine interrupt enable
    localparam int MIE_MEIE    = 11;  // Machine external interrupt enable

    // Interrupt flag in the top bit, machine external cause 11 below
    localparam xlen_t MCAUSE_EXT_IRQ = {1'b1, 63'd11};

    // Interrupt service sequence
    typedef enum logic [1:0] {
        IRQ_IDLE,        // Waiting for a qualified request
        IRQ_READ,        // Key read on the bus
        IRQ_WRITE,       // Echo to display, redirect armed
        IRQ_WAIT_CLEAR   // Source must drop before next trigger
    } irq_state_t;

endpackage

// ==== compile.f ====
+incdir+common
common/riscv_pkg.sv
common/mem_bus_if.sv
common/csr_if.sv
core/instr_fetch.sv
core/exec_unit.sv
core/reg_file.sv
core/trap_ctrl.sv
hw/riscv_core.sv
tests/riscv_core_assert.sv
tests/riscv_core_tb.sv

// ==== core/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import riscv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  instr_t   ir,
    input  logic     bubble,     // Squash the current ir
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output reg_idx_t rd_idx,
    output logic     rd_we,      // Register write at next edge
    output xlen_t    rd_data,
    csr_if.req       csr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_u;
    xlen_t      imm_i;
    logic       is_lui;
    logic       is_addi;
    logic       is_add;
    logic       is_csrrw;
    logic       active;    // ir may change state this cycle
    logic       run;       // Set once the first fetch has landed

    // Field extraction
    assign opcode  = ir[6:0];
    assign rd_idx  = ir[11:7];
    assign funct3  = ir[14:12];
    assign rs1_idx = ir[19:15];
    assign rs2_idx = ir[24:20];
    assign funct7  = ir[31:25];

    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};  // Sign-extended upper immediate
    assign imm_i = {{52{ir[31]}}, ir[31:20]};

    // Supported forms only, anything else falls through as a no-op
    assign is_lui   = (opcode == OP_LUI);
    assign is_addi  = (opcode == OP_IMM) && (funct3 == F3_ADD);
    assign is_add   = (opcode == OP_REG) && (funct3 == F3_ADD) && (funct7 == F7_ADD);
    assign is_csrrw = (opcode == OP_SYSTEM) && (funct3 == F3_CSRRW);

    // Nothing retires before ir has seen a real fetch
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    assign active = run && !bubble;

    // CSR port, swap rs1 into the CSR
    assign csr.addr  = ir[31:20];
    assign csr.wdata = rs1_data;
    assign csr.we    = active && is_csrrw;

    // Writes to x0 never reach the register file
    assign rd_we = active && (is_lui || is_addi || is_add || is_csrrw)
                   && (rd_idx != '0);

    // Result mux
    always_comb begin
        rd_data = '0;
        if (is_lui) begin
            rd_data = imm_u;
        end else if (is_addi) begin
            rd_data = rs1_data + imm_i;
        end else if (is_add) begin
            rd_data = rs1_data + rs2_data;
        end else if (is_csrrw) begin
            rd_data = csr.rdata;   // Value before this write
        end
    end

endmodule

// ==== core/instr_fetch.sv ====
`timescale 1ns/1ps
`include "riscv_params.svh"

module instr_fetch import riscv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  instr_t      instruction,  // Word at the current pc
    input  logic        redirect,     // Jump request from trap_ctrl
    input  logic [31:0] redirect_pc,
    output logic [31:0] pc,
    output instr_t      ir,
    output logic        bubble,       // ir holds a wrong-path fetch
    output logic        heartbeat
);

    // Instruction register and liveness toggle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= '0;     // Zero word decodes as no-op
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;
        end
    end

    // Program counter
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc     <= `RESET_PC;
            bubble <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;   // Trap vector
            end else begin
                pc <= pc + 32'd4;
            end
            // Word fetched alongside the jump is from the old path
            bubble <= redirect;
        end
    end

endmodule

// ==== core/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import riscv_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t rd_idx,
    input  logic     rd_we,
    input  xlen_t    rd_data,
    input  reg_idx_t dbg_reg,   // Observation index
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    output xlen_t    dbg_data
);

    xlen_t regs [32];

    // Single write port
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we) begin
            regs[rd_idx] <= rd_data;
        end
    end

    // Combinational reads with x0 hardwired
    always_comb begin
        rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
        rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];
        dbg_data = (dbg_reg == '0) ? '0 : regs[dbg_reg];  // Debug view
    end

endmodule

// ==== core/trap_ctrl.sv ====
`timescale 1ns/1ps
`include "riscv_params.svh"

module trap_ctrl import riscv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  interrupt_vector,  // Active source number
    output logic        redirect,          // Jump to redirect_pc at next edge
    output logic [31:0] redirect_pc,
    output logic        interrupt_done,    // One-cycle completion pulse
    mem_bus_if.master   bus,
    csr_if.rsp          csr
);

    xlen_t      mstatus;
    xlen_t      mie;
    xlen_t      mtvec;
    xlen_t      mcause;
    irq_state_t state;
    logic       irq_req;    // Key source with both enables

    assign irq_req = (interrupt_vector == `KEY_IRQ_SRC)
                     && mstatus[MSTATUS_MIE] && mie[MIE_MEIE];

    // CSR read, old value during a write
    always_comb begin
        case (csr.addr)
            CSR_MSTATUS: csr.rdata = mstatus;
            CSR_MIE:     csr.rdata = mie;
            CSR_MTVEC:   csr.rdata = mtvec;
            CSR_MCAUSE:  csr.rdata = mcause;
            default:     csr.rdata = '0;   // Unimplemented CSRs read zero
        endcase
    end

    // Redirect armed during the echo write cycle
    assign redirect    = (state == IRQ_WRITE);
    assign redirect_pc = mtvec[31:0];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus          <= '0;
            mie              <= '0;
            mtvec            <= '0;
            mcause           <= '0;
            state            <= IRQ_IDLE;
            bus.address      <= '0;
            bus.write_data   <= '0;
            bus.read_enable  <= 1'b0;
            bus.write_enable <= 1'b0;
            interrupt_done   <= 1'b0;
        end else begin
            // Strobes default low
            bus.read_enable  <= 1'b0;
            bus.write_enable <= 1'b0;
            interrupt_done   <= 1'b0;

            // Software writes from CSRRW
            if (csr.we) begin
                case (csr.addr)
                    CSR_MSTATUS: mstatus <= csr.wdata;
                    CSR_MIE:     mie     <= csr.wdata;
                    CSR_MTVEC:   mtvec   <= csr.wdata;
                    CSR_MCAUSE:  mcause  <= csr.wdata;
                    default:     ;
                endcase
            end

            unique case (state)
                IRQ_IDLE: begin
                    if (irq_req) begin
                        bus.address     <= `KEY_BASE;
                        bus.read_enable <= 1'b1;
                        state           <= IRQ_READ;
                    end
                end
                IRQ_READ: begin
                    // Key data present at this edge
                    bus.write_data   <= bus.read_data;
                    bus.address      <= `ART_BASE;
                    bus.write_enable <= 1'b1;
                    mcause           <= MCAUSE_EXT_IRQ;  // Wins over a CSRRW
                    state            <= IRQ_WRITE;
                end
                IRQ_WRITE: begin
                    interrupt_done <= 1'b1;   // pc loads mtvec at this edge
                    state          <= IRQ_WAIT_CLEAR;
                end
                IRQ_WAIT_CLEAR: begin
                    // Level source, rearm only once it drops
                    if (interrupt_vector != `KEY_IRQ_SRC) begin
                        state <= IRQ_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core import riscv_pkg::*; (
    input  logic        clk,
    input  logic        reset,            // Active low
    input  instr_t      instruction,
    input  logic [3:0]  interrupt_vector,
    input  xlen_t       bus_read_data,
    input  reg_idx_t    dbg_reg,          // Register to observe
    output logic [31:0] pc,
    output instr_t      ir,
    output logic        heartbeat,
    output logic        interrupt_done,
    output xlen_t       bus_address,
    output xlen_t       bus_write_data,
    output logic        bus_write_enable,
    output logic        bus_read_enable,
    output xlen_t       dbg_data
);

    logic        bubble;       // Drop the instruction in ir
    logic        redirect;     // Load redirect_pc at next edge
    logic [31:0] redirect_pc;

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    logic     rd_we;
    xlen_t    rd_data;
    xlen_t    rs1_data;
    xlen_t    rs2_data;

    mem_bus_if bus_if ();
    csr_if     csr_bus ();

    // Bus interface onto plain pins
    assign bus_address       = bus_if.address;
    assign bus_write_data    = bus_if.write_data;
    assign bus_write_enable  = bus_if.write_enable;
    assign bus_read_enable   = bus_if.read_enable;
    assign bus_if.read_data  = bus_read_data;

    instr_fetch u_instr_fetch (
        .clk, .reset, .instruction, .redirect, .redirect_pc,
        .pc, .ir, .bubble, .heartbeat
    );

    exec_unit u_exec_unit (
        .clk, .reset, .ir, .bubble, .rs1_data, .rs2_data,
        .rs1_idx, .rs2_idx, .rd_idx, .rd_we, .rd_data,
        .csr (csr_bus.req)
    );

    reg_file u_reg_file (
        .clk, .reset, .rs1_idx, .rs2_idx, .rd_idx, .rd_we, .rd_data,
        .dbg_reg, .rs1_data, .rs2_data, .dbg_data
    );

    trap_ctrl u_trap_ctrl (
        .clk, .reset, .interrupt_vector,
        .redirect, .redirect_pc, .interrupt_done,
        .bus (bus_if.master),
        .csr (csr_bus.rsp)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module riscv_core_tb \
    -Mdir obj_dir -o riscv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let assertion errors accumulate so the testbench reaches its summary
output="$(./obj_dir/riscv_core_sim +verilator+error+limit+100)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== tests/riscv_core_assert.sv ====
`timescale 1ns/1ps

// Protocol checks on the trap controller, attached with bind
module riscv_core_assert import riscv_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        read_enable,
    input logic        write_enable,
    input logic        interrupt_done,
    input logic [31:0] pc,          // Fetch pc of the core
    input xlen_t       mtvec
);

    int fail_count = 0;  // Failed assertion tally

    // Read strobe lasts one cycle only
    a_read_single: assert property (@(posedge clk) disable iff (!reset)
        read_enable |=> !read_enable)
        else begin
            fail_count++;
            $error("bus read strobe held two cycles");
        end

    // Echo write exactly one cycle after the key read
    a_write_after_read: assert property (@(posedge clk) disable iff (!reset)
        read_enable |=> write_enable)
        else begin
            fail_count++;
            $error("no bus write after key read");
        end

    a_write_has_read: assert property (@(posedge clk) disable iff (!reset)
        write_enable |-> $past(read_enable))
        else begin
            fail_count++;
            $error("bus write without preceding read");
        end

    // Done pulses on the edge that loads pc with the trap vector
    a_done_pc: assert property (@(posedge clk) disable iff (!reset)
        interrupt_done |-> (pc == mtvec[31:0]))
        else begin
            fail_count++;
            $error("pc differs from mtvec while interrupt_done is high");
        end

endmodule

// ==== tests/riscv_core_tb.sv ====
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscv_core_tb import riscv_pkg::*; ();

    localparam int N_RAND  = 20;  // Random LUI/ADDI
    localparam int N_ADD   = 12;  // ADD chain length
    localparam int N_FIXED = 11;  // CSR setup, readbacks, mcause, mie clear
    localparam int N_QUIET = 8;   // Cycles per no-strobe window
    localparam int LIMIT   = 2 * (18 + 3 * (N_RAND + N_ADD + N_FIXED) + 8 + 2 * N_QUIET + 4);

    logic        clk = 1'b0;
    logic        reset;
    instr_t      instruction;
    logic [3:0]  interrupt_vector;
    xlen_t       bus_read_data;
    reg_idx_t    dbg_reg;
    logic [31:0] pc;
    instr_t      ir;
    logic        heartbeat;
    logic        interrupt_done;
    xlen_t       bus_address;
    xlen_t       bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    xlen_t       dbg_data;

    xlen_t model_regs [32];  // Architectural mirror
    xlen_t model_csrs [4];   // mstatus, mie, mtvec, mcause
    int    error_count = 0;
    int    check_count = 0;
    int    cycle_count = 0;

    riscv_core u_riscv_core (.*);

    bind trap_ctrl riscv_core_assert u_trap_assert (
        .clk, .reset, .read_enable(bus.read_enable), .write_enable(bus.write_enable),
        .interrupt_done, .pc(u_instr_fetch.pc), .mtvec
    );

    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= LIMIT) begin
            $display("Timeout: DUT did not finish within %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic instr_t enc_lui(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic instr_t enc_addi(input reg_idx_t rd, input reg_idx_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic instr_t enc_add(input reg_idx_t rd, input reg_idx_t rs1,
                                       input reg_idx_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic instr_t enc_csrrw(input reg_idx_t rd, input csr_addr_t csr,
                                         input reg_idx_t rs1);
        return {csr, rs1, 3'b001, rd, 7'b1110011};
    endfunction

    function automatic int csr_slot(input csr_addr_t addr);
        case (addr)
            12'h300: return 0;
            12'h304: return 1;
            12'h305: return 2;
            12'h342: return 3;
            default: return -1;  // Reads zero, ignores writes
        endcase
    endfunction

    // Reference semantics of the four supported instructions
    function automatic void ref_exec(input instr_t instr);
        reg_idx_t rd;
        xlen_t    result;
        logic     wr;
        int       slot;
        rd     = instr[11:7];
        wr     = 1'b1;
        result = '0;
        slot   = csr_slot(instr[31:20]);
        case (instr[6:0])
            7'h37: result = xlen_t'($signed({instr[31:12], 12'h000}));
            7'h13: result = model_regs[instr[19:15]] + xlen_t'($signed(instr[31:20]));
            7'h33: result = model_regs[instr[19:15]] + model_regs[instr[24:20]];
            7'h73: begin
                wr = (instr[14:12] == 3'b001);
                if (slot >= 0) begin
                    result           = model_csrs[slot];  // Old value to rd
                    model_csrs[slot] = model_regs[instr[19:15]];
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != '0) model_regs[rd] = result;
    endfunction

    function automatic void ref_irq_expect(input xlen_t key, output xlen_t echo,
                                           output xlen_t cause, output logic [31:0] target);
        echo          = key;                      // Display gets the key as read
        cause         = 64'h8000_0000_0000_000B;  // Interrupt flag, external cause 11
        target        = model_csrs[2][31:0];      // mtvec
        model_csrs[3] = cause;
    endfunction

    task automatic check_reg(input string name, input xlen_t exp, input xlen_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_bus(input string name, input xlen_t exp_addr, input xlen_t exp_data,
                             input xlen_t act_addr, input xlen_t act_data);
        check_count++;
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            error_count++;
            $display("** Error %s: expected %h/%h, actual %h/%h", name,
                     exp_addr, exp_data, act_addr, act_data);
        end
    endtask

    // Issue one instruction, then look at rd after its write edge
    task automatic run_instr(input string name, input instr_t instr);
        @(negedge clk);
        instruction = instr;
        ref_exec(instr);
        @(negedge clk);
        check_instr({name, "_ir"}, instr, ir);  // Latched at the first edge
        instruction = '0;
        @(negedge clk);
        dbg_reg = instr[11:7];
        #1;
        check_reg(name, model_regs[instr[11:7]], dbg_data);
    endtask

    task automatic watch_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag({name, "_read"}, 1'b0, bus_read_enable);
            check_flag({name, "_write"}, 1'b0, bus_write_enable);
            check_flag({name, "_done"}, 1'b0, interrupt_done);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] imm;
        logic [31:0] exp_pc;
        logic [31:0] exp_target;
        logic        exp_hb;
        reg_idx_t    rd;
        reg_idx_t    prev;
        xlen_t       key;
        xlen_t       exp_echo;
        xlen_t       exp_cause;
        rnd              = $urandom(7);
        reset            = 1'b0;
        instruction      = '0;
        interrupt_vector = '0;
        bus_read_data    = '0;
        dbg_reg          = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < 4; i++) model_csrs[i] = '0;
        repeat (10) @(negedge clk);

        // Reset state, then free-running pc
        check_pc("reset_pc", `RESET_PC, pc);
        check_pc("reset_ir", 32'h0, ir);
        check_flag("reset_read", 1'b0, bus_read_enable);
        check_flag("reset_write", 1'b0, bus_write_enable);
        check_flag("reset_done", 1'b0, interrupt_done);
        check_flag("reset_heartbeat", 1'b0, heartbeat);
        reset  = 1'b1;
        exp_pc = `RESET_PC;
        exp_hb = 1'b0;
        repeat (8) begin
            @(negedge clk);
            exp_pc = exp_pc + 32'd4;
            exp_hb = ~exp_hb;                    // Flips on every edge
            check_pc("pc_step", exp_pc, pc);
            check_flag("heartbeat_toggle", exp_hb, heartbeat);
        end

        for (int i = 0; i < N_RAND; i++) begin
            rnd = $urandom;
            imm = $urandom;
            rd  = (i % 5 == 0) ? 5'd0 : rnd[4:0];  // Some writes aimed at x0
            if (rnd[8]) run_instr("lui", enc_lui(rd, imm[19:0]));
            else run_instr("addi", enc_addi(rd, rnd[13:9], imm[11:0]));
        end

        prev = 5'd1;
        for (int i = 0; i < N_ADD; i++) begin
            rnd = $urandom;
            rd  = (rnd[4:0] == '0) ? 5'd31 : rnd[4:0];
            run_instr("add_chain", enc_add(rd, prev, rnd[9:5]));  // Reads the last result
            prev = rd;
        end

        // CSR swaps, second of each pair reads back
        run_instr("csr_setup", enc_addi(5'd5, 5'd0, 12'h200));
        run_instr("mtvec_swap", enc_csrrw(5'd6, CSR_MTVEC, 5'd5));
        run_instr("mtvec_back", enc_csrrw(5'd6, CSR_MTVEC, 5'd5));
        run_instr("csr_setup", enc_addi(5'd7, 5'd0, 12'h800));  // MEIE bit
        run_instr("mie_swap", enc_csrrw(5'd8, CSR_MIE, 5'd7));
        run_instr("mie_back", enc_csrrw(5'd8, CSR_MIE, 5'd7));
        run_instr("csr_setup", enc_addi(5'd9, 5'd0, 12'h008));  // Global MIE
        run_instr("mstatus_swap", enc_csrrw(5'd10, CSR_MSTATUS, 5'd9));
        run_instr("mstatus_back", enc_csrrw(5'd10, CSR_MSTATUS, 5'd9));

        // Key interrupt
        key = {$urandom, $urandom};
        ref_irq_expect(key, exp_echo, exp_cause, exp_target);
        @(negedge clk);
        interrupt_vector = `KEY_IRQ_SRC;
        @(negedge clk);
        while (!bus_read_enable) @(negedge clk);
        check_bus("irq_read", `KEY_BASE, '0, bus_address, bus_write_data);
        bus_read_data = key;
        @(negedge clk);
        check_flag("irq_write_strobe", 1'b1, bus_write_enable);
        check_bus("irq_echo", `ART_BASE, exp_echo, bus_address, bus_write_data);
        bus_read_data = '0;
        instruction   = enc_addi(5'd11, 5'd0, 12'h5A5);  // Redirect-cycle fetch
        @(negedge clk);
        instruction = '0;
        check_flag("irq_done", 1'b1, interrupt_done);
        check_pc("irq_target", exp_target, pc);
        @(negedge clk);
        check_pc("irq_next", exp_target + 32'd4, pc);
        dbg_reg = 5'd11;
        #1;
        check_reg("irq_bubble", model_regs[11], dbg_data);
        run_instr("mcause_read", enc_csrrw(5'd12, CSR_MCAUSE, 5'd0));
        check_reg("mcause_value", exp_cause, dbg_data);

        // No retrigger on a held source, none with MEIE cleared
        watch_quiet("held_source", N_QUIET);
        run_instr("mie_clear", enc_csrrw(5'd0, CSR_MIE, 5'd0));
        @(negedge clk);
        interrupt_vector = '0;
        @(negedge clk);
        interrupt_vector = `KEY_IRQ_SRC;
        watch_quiet("masked", N_QUIET);

        error_count += u_riscv_core.u_trap_ctrl.u_trap_assert.fail_count;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
